// ==== pixelGen.f ====
+incdir+test
rtl/pixelGenPkg.sv
rtl/drawPosition.sv
rtl/squareLayer.sv
rtl/sceneFade.sv
rtl/pixelFifo.sv
rtl/pixelGen.sv
test/pixelGenTb.sv

// ==== runSim.sh ====
#!/bin/sh
# builds the pixel generator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert --top-module pixelGenTb \
	-f pixelGen.f -o pixelGenSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "runSim: Verilator build failed"
	exit 1
fi

./obj_dir/pixelGenSim > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
	echo "runSim: simulation exited with status $simStatus"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$SIM_LOG"; then
	echo "runSim: simulation passed"
	exit 0
fi
echo "runSim: pass line missing from $SIM_LOG"
exit 1

// ==== test/pixelGenTests.svh ====
// rectangle setup, configuration under reset, read handshake and the directed tests

// --------------------------------------------------
// stimulus helpers
// --------------------------------------------------
function automatic squareT makeSquare(input rgbT color, input int l, input int r,
	input int t, input int u);
	squareT sq;
	sq.color = color;
	sq.left  = edgeT'(l);
	sq.right = edgeT'(r);
	sq.top   = edgeT'(t);
	sq.under = edgeT'(u);
	return sq;
endfunction

task automatic loadSquares();
	int l;
	int t;
	int w;
	int h;
	rgbT color;
	// first and last rectangle random and may start left of or above the screen
	for (int i = 0; i < lpSquareNum; i += lpSquareNum - 1)
	begin
		l = int'(randBits(6)) - 16;
		w = int'(randBits(5));
		t = int'(randBits(5)) - 8;
		h = int'(randBits(4));
		color = rgbT'(randBits(12));
		squares[i] = makeSquare(color, l, l + w, t, t + h);
	end
	// crosses the top left corner
	squares[1] = makeSquare(12'h0F0, -5, 6, -3, 4);
	// hangs off the bottom right
	squares[2] = makeSquare(12'h00F, 28, 40, 12, 20);
	// left > right paints nothing
	squares[3] = makeSquare(12'hFFF, 10, 5, 0, 15);
	squares[4] = makeSquare(12'hA50, 4, 20, 2, 13);
	// never on screen
	squares[5] = makeSquare(12'h5C3, 100, 120, 30, 40);
endtask

// configuration only changes under reset
// returns on the falling edge of release
task automatic applyConfig(input sceneCtrlT ctrl, input bit newSquares);
	@(negedge iCLK);
	iRST = 1'b1;
	re = 1'b0;
	sceneCtrl = ctrl;
	if (newSquares)
	begin
		loadSquares();
	end
	repeat (lpResetCycles) @(negedge iCLK);
	iRST = 1'b0;
	pixIdx = 0;
endtask

// one read strobe once data is there
// rdValid must come one cycle later
task automatic readPixel(input string testName, output rgbT value);
	int waitCnt;
	waitCnt = 0;
	while (empty)
	begin
		@(negedge iCLK);
		waitCnt++;
		assert (waitCnt <= lpDataTimeout)
		else stopOnError($sformatf("%s: FIFO stayed empty too long", testName));
	end
	re = 1'b1;
	@(negedge iCLK);
	re = 1'b0;
	waitCnt = 1;
	while (!rdValid)
	begin
		@(negedge iCLK);
		waitCnt++;
		assert (waitCnt <= lpValidTimeout)
		else stopOnError($sformatf("%s: no rdValid after a read strobe", testName));
	end
	checkValue({testName, " read latency"}, 1, waitCnt);
	value = rd;
endtask

task automatic readAndCompare(input string testName, input int count, input bit withGaps);
	rgbT actual;
	int idle;
	repeat (count)
	begin
		if (withGaps)
		begin
			// mostly short gaps with now and then a long stall that fills the FIFO
			idle = (randBits(4) == 0) ? int'(randBits(9)) % 301 : int'(randBits(2));
			repeat (idle) @(negedge iCLK);
		end
		readPixel(testName, actual);
		checkValue($sformatf("%s pixel %0d", testName, pixIdx),
			int'(expectedPixel(pixIdx)), int'(actual));
		pixIdx++;
	end
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic testResetState();
	sceneCtrlT ctrl;
	ctrl = '0;
	ctrl.color = 12'h248;
	applyConfig(ctrl, 1'b0);
	checkValue("resetState rdValid", 0, int'(rdValid));
	checkValue("resetState alphaMin", 1, int'(sceneAlphaMin));
	checkValue("resetState alphaMax", 0, int'(sceneAlphaMax));
	checkValue("resetState frameEnd", 0, int'(oFrameEnd));
	checkValue("resetState empty", 1, int'(empty));
	// strobe into an empty FIFO is dropped
	re = 1'b1;
	@(negedge iCLK);
	re = 1'b0;
	checkValue("resetState strobe on empty", 0, int'(rdValid));
	@(negedge iCLK);
	checkValue("resetState strobe on empty", 0, int'(rdValid));
endtask

task automatic testRectangles();
	sceneCtrlT ctrl;
	ctrl = '0;
	ctrl.color = 12'hF80;
	applyConfig(ctrl, 1'b0);
	readAndCompare("rectangles", 2 * lpFramePixels, 1'b0);
	// the raster runs ahead of the reads by less than one frame
	checkValue("rectangles frame ends", 2, frameEnds);
endtask

task automatic testStalls();
	sceneCtrlT ctrl;
	ctrl = '0;
	ctrl.color = 12'h0FF;
	applyConfig(ctrl, 1'b1);
	readAndCompare("stalls", 1200, 1'b1);
endtask

task automatic testFadeUp();
	sceneCtrlT ctrl;
	ctrl = '0;
	ctrl.color = 12'h3C9;
	ctrl.frameTiming = 7'd1;
	ctrl.addEn = 1'b1;
	applyConfig(ctrl, 1'b0);
	readAndCompare("fadeUp", 40 * lpFramePixels, 1'b0);
	checkValue("fadeUp alphaMax", 1, int'(sceneAlphaMax));
	checkValue("fadeUp alphaMin", 0, int'(sceneAlphaMin));
endtask

// runs straight after the fade up with the level still at the top
task automatic testFadeDownReset();
	sceneCtrlT ctrl;
	sceneCtrl.fadeRst = 1'b1;
	@(negedge iCLK);
	sceneCtrl.fadeRst = 1'b0;
	checkValue("fadeDownReset alphaMin", 1, int'(sceneAlphaMin));
	checkValue("fadeDownReset alphaMax", 0, int'(sceneAlphaMax));
	// fading down from level 0 stays at 0 and gives plain square pixels
	ctrl = '0;
	ctrl.color = 12'h3C9;
	ctrl.frameTiming = 7'd1;
	ctrl.subEn = 1'b1;
	applyConfig(ctrl, 1'b0);
	readAndCompare("fadeDownReset", 3 * lpFramePixels, 1'b0);
	checkValue("fadeDownReset alphaMin", 1, int'(sceneAlphaMin));
endtask

// ==== test/pixelGenTb.sv ====
// testbench top with clock, DUT instance, LFSR, reference model and test sequence
`timescale 1ns/100ps

module pixelGenTb
	import pixelGenPkg::*;
();

	localparam int lpHActive = 32;
	localparam int lpVActive = 16;
	localparam int lpFramePixels = lpHActive * lpVActive;
	localparam int lpResetCycles = 5;
	// cycles allowed for data to show up and for rdValid after a strobe
	localparam int lpDataTimeout = 100;
	localparam int lpValidTimeout = 4;

	logic iCLK = 1'b0;
	logic iRST;
	squareT squares [lpSquareNum];
	sceneCtrlT sceneCtrl;
	logic re;
	rgbT rd;
	logic rdValid;
	logic empty;
	logic oFrameEnd;
	logic sceneAlphaMax;
	logic sceneAlphaMin;
	logic [31:0] lfsr;
	// raster index of the next pixel expected from the FIFO
	int pixIdx;
	// frame-end strobes seen since the last reset
	int frameEnds;

	always #10 iCLK = ~iCLK;

	pixelGen #(
		.pHActive (lpHActive),
		.pVActive (lpVActive)
	) uut (
		.iCLK          (iCLK),
		.iRST          (iRST),
		.squares       (squares),
		.sceneCtrl     (sceneCtrl),
		.re            (re),
		.rd            (rd),
		.rdValid       (rdValid),
		.empty         (empty),
		.oFrameEnd     (oFrameEnd),
		.sceneAlphaMax (sceneAlphaMax),
		.sceneAlphaMin (sceneAlphaMin)
	);

	// counted like a register on the rising edge
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			frameEnds <= 0;
		end
		else if (oFrameEnd)
		begin
			frameEnds <= frameEnds + 1;
		end
	end

	// --------------------------------------------------
	// LFSR with x^32 + x^22 + x^2 + x + 1
	// --------------------------------------------------
	// one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// first rectangle in index order that covers the pixel or black
	function automatic rgbT squarePixel(input int h, input int v);
		for (int i = 0; i < lpSquareNum; i++)
		begin
			if ((int'(squares[i].left) <= h) && (h <= int'(squares[i].right))
				&& (int'(squares[i].top) <= v) && (v <= int'(squares[i].under)))
			begin
				return squares[i].color;
			end
		end
		return '0;
	endfunction

	// one step every frameTiming + 1 frames up to the top level
	function automatic int fadeLevel(input int idx);
		int steps;
		steps = (idx / lpFramePixels) / (int'(sceneCtrl.frameTiming) + 1);
		if (!sceneCtrl.addEn)
		begin
			return 0;
		end
		return (steps > lpFadeMax) ? lpFadeMax : steps;
	endfunction

	function automatic rgbT blendPixel(input rgbT src, input rgbT dst, input int lvl);
		rgbT result;
		int mix;
		for (int c = 0; c < 3; c++)
		begin
			mix = (int'(src[c*lpChanWidth +: lpChanWidth]) * (lpFadeMax - lvl)
				+ int'(dst[c*lpChanWidth +: lpChanWidth]) * lvl) >> 4;
			result[c*lpChanWidth +: lpChanWidth] = mix[lpChanWidth-1:0];
		end
		return result;
	endfunction

	function automatic rgbT expectedPixel(input int idx);
		int p;
		p = idx % lpFramePixels;
		return blendPixel(squarePixel(p % lpHActive, p / lpHActive), sceneCtrl.color,
			fadeLevel(idx));
	endfunction

	// --------------------------------------------------
	// error reporting
	// --------------------------------------------------
	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			stopOnError($sformatf("FAILED %s expected %0h actual %0h",
				testName, expected, actual));
		end
	endtask

	`include "pixelGenTests.svh"

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin
		lfsr = 32'h8814;
		iRST = 1'b1;
		re = 1'b0;
		sceneCtrl = '0;
		pixIdx = 0;
		loadSquares();
		testResetState();
		testRectangles();
		testStalls();
		testFadeUp();
		testFadeDownReset();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== rtl/pixelGen.sv ====
// top level joining position counter, square layer, scene fade and output FIFO
`timescale 1ns/100ps

module pixelGen
	import pixelGenPkg::*;
#(
	parameter int pHActive = 480,
	parameter int pVActive = 272
)(
	input  logic      iCLK,
	input  logic      iRST,
	input  squareT    squares [lpSquareNum],
	input  sceneCtrlT sceneCtrl,
	input  logic      re,
	output rgbT       rd,
	output logic      rdValid,
	output logic      empty,
	output logic      oFrameEnd,
	output logic      sceneAlphaMax,
	output logic      sceneAlphaMin
);

	// --------------------------------------------------
	// stage links
	// --------------------------------------------------
	drawPosT posSlot;
	pixelStageT squarePixel;
	pixelStageT fadePixel;
	// FIFO back to the counter
	logic fifoRoom;

	drawPosition #(
		.pHActive (pHActive),
		.pVActive (pVActive)
	) drawPosition (
		.iCLK (iCLK),
		.iRST (iRST),
		.room (fifoRoom),
		.pos  (posSlot)
	);

	// one cycle
	squareLayer squareLayer (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.pos      (posSlot),
		.squares  (squares),
		.pixelOut (squarePixel)
	);

	// one cycle, output goes straight into the FIFO
	sceneFade sceneFade (
		.iCLK          (iCLK),
		.iRST          (iRST),
		.pixelIn       (squarePixel),
		.sceneCtrl     (sceneCtrl),
		.pixelOut      (fadePixel),
		.sceneAlphaMax (sceneAlphaMax),
		.sceneAlphaMin (sceneAlphaMin)
	);

	pixelFifo pixelFifo (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.pixelIn (fadePixel),
		.re      (re),
		.rd      (rd),
		.rdValid (rdValid),
		.empty   (empty),
		.room    (fifoRoom)
	);

	// frame end as issued by the counter
	assign oFrameEnd = posSlot.frameEnd;

endmodule

// ==== rtl/pixelFifo.sv ====
// synchronous pixel FIFO with registered read, empty flag and room for in-flight pixels
`timescale 1ns/100ps

module pixelFifo
	import pixelGenPkg::*;
(
	input  logic       iCLK,
	input  logic       iRST,
	input  pixelStageT pixelIn,
	input  logic       re,
	output rgbT        rd,
	output logic       rdValid,
	output logic       empty,
	output logic       room
);

	// --------------------------------------------------
	// storage and pointers
	// --------------------------------------------------
	rgbT mem [lpFifoDepth];
	// depth is a power of two, pointers wrap by themselves
	fifoPtrT wrPtr;
	fifoPtrT rdPtr;
	fifoCntT cnt;
	logic wrEn;
	logic rdEn;
	logic full;

	// every valid pixel is written, room guarantees space
	assign wrEn = pixelIn.valid;
	// strobe while empty is dropped
	assign rdEn = re & ~empty;

	assign empty = (cnt == '0);
	assign full  = (cnt == fifoCntT'(lpFifoDepth));
	// leave space for the pixels already in the pipe
	assign room  = (cnt + fifoCntT'(lpPipeDepth)) < fifoCntT'(lpFifoDepth);

	always_ff @(posedge iCLK)
	begin
		if (wrEn)
		begin
			mem[wrPtr] <= pixelIn.pixel;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			cnt   <= '0;
		end
		else
		begin
			if (wrEn)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (rdEn)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			// simultaneous write and read keeps the count
			case ({wrEn, rdEn})
				2'b10: cnt <= cnt + 1'b1;
				2'b01: cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
		end
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------
	// oldest pixel one cycle after the strobe
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			rdValid <= 1'b0;
		end
		else
		begin
			rdValid <= rdEn;
		end
		if (rdEn)
		begin
			rd <= mem[rdPtr];
		end
	end

	// upstream throttling must keep a full FIFO from seeing a write
	assert property (@(posedge iCLK) disable iff (iRST)
		full |-> !pixelIn.valid);

endmodule

// ==== rtl/sceneFade.sv ====
// fade level control per frame and per-channel blend toward the scene color
`timescale 1ns/100ps

module sceneFade
	import pixelGenPkg::*;
(
	input  logic       iCLK,
	input  logic       iRST,
	input  pixelStageT pixelIn,
	input  sceneCtrlT  sceneCtrl,
	output pixelStageT pixelOut,
	output logic       sceneAlphaMax,
	output logic       sceneAlphaMin
);

	fadeT level;
	frameTimingT frameCnt;
	logic frameDone;
	logic stepNow;
	rgbT blended;

	// --------------------------------------------------
	// blend
	// --------------------------------------------------
	// (src * (16 - lvl) + dst * lvl) >> 4
	// max sum 15 * 16 fits in 9 bits
	function automatic chanT blendChannel(input chanT src, input chanT dst, input fadeT lvl);
		logic [8:0] mix;
		mix = 9'(src) * 9'(fadeT'(lpFadeMax) - lvl) + 9'(dst) * 9'(lvl);
		return mix[7:4];
	endfunction

	// r, g and b handled alike
	always_comb
	begin
		for (int c = 0; c < 3; c++)
		begin
			blended[c*lpChanWidth +: lpChanWidth] = blendChannel(
				pixelIn.pixel[c*lpChanWidth +: lpChanWidth],
				sceneCtrl.color[c*lpChanWidth +: lpChanWidth],
				level);
		end
	end

	// --------------------------------------------------
	// frame counter and fade level
	// --------------------------------------------------
	// last pixel of a frame passing through this stage
	assign frameDone = pixelIn.valid & pixelIn.frameEnd;
	// step once every frameTiming + 1 frames
	assign stepNow = frameDone & (frameCnt == sceneCtrl.frameTiming);

	// updates on the edge that registers the frame-end pixel
	// first pixel of the next frame already sees the new level
	always_ff @(posedge iCLK)
	begin
		if (iRST || sceneCtrl.fadeRst)
		begin
			level    <= '0;
			frameCnt <= '0;
		end
		else if (stepNow)
		begin
			frameCnt <= '0;
			// add wins if both are set
			if (sceneCtrl.addEn && (level < fadeT'(lpFadeMax)))
			begin
				level <= level + 1'b1;
			end
			else if (sceneCtrl.subEn && (level != '0))
			begin
				level <= level - 1'b1;
			end
		end
		else if (frameDone)
		begin
			frameCnt <= frameCnt + 1'b1;
		end
	end

	// level limits
	assign sceneAlphaMax = (level == fadeT'(lpFadeMax));
	assign sceneAlphaMin = (level == '0);

	// --------------------------------------------------
	// stage register
	// --------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pixelOut.valid    <= 1'b0;
			pixelOut.frameEnd <= 1'b0;
		end
		else
		begin
			pixelOut.valid    <= pixelIn.valid;
			pixelOut.frameEnd <= pixelIn.frameEnd;
		end
		if (pixelIn.valid)
		begin
			pixelOut.pixel <= blended;
		end
	end

	// level stays in range
	assert property (@(posedge iCLK) disable iff (iRST)
		level <= fadeT'(lpFadeMax));

endmodule

// ==== rtl/squareLayer.sv ====
// seven-rectangle hit test with lowest-index priority and a registered pixel
`timescale 1ns/100ps

module squareLayer
	import pixelGenPkg::*;
(
	input  logic       iCLK,
	input  logic       iRST,
	input  drawPosT    pos,
	input  squareT     squares [lpSquareNum],
	output pixelStageT pixelOut
);

	// --------------------------------------------------
	// signed position
	// --------------------------------------------------
	edgeT hEdge;
	edgeT vEdge;
	logic [lpSquareNum-1:0] hit;
	rgbT pixelNext;

	// zero extend so the compare against negative edges works
	assign hEdge = {1'b0, pos.hpos};
	assign vEdge = {1'b0, pos.vpos};

	// --------------------------------------------------
	// parallel hit test
	// --------------------------------------------------
	// inclusive on all four edges
	// empty rectangles fail one of the two ranges by themselves
	always_comb
	begin
		for (int i = 0; i < lpSquareNum; i++)
		begin
			hit[i] = (squares[i].left <= hEdge) && (hEdge <= squares[i].right)
				&& (squares[i].top <= vEdge) && (vEdge <= squares[i].under);
		end
	end

	// black by default
	// walk downward so the lowest index is written last and wins
	always_comb
	begin
		pixelNext = '0;
		for (int i = lpSquareNum - 1; i >= 0; i--)
		begin
			if (hit[i])
			begin
				pixelNext = squares[i].color;
			end
		end
	end

	// --------------------------------------------------
	// stage register
	// --------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pixelOut.valid    <= 1'b0;
			pixelOut.frameEnd <= 1'b0;
		end
		else
		begin
			pixelOut.valid    <= pos.valid;
			pixelOut.frameEnd <= pos.frameEnd;
		end
		// payload only moves with a real pixel
		if (pos.valid)
		begin
			pixelOut.pixel <= pixelNext;
		end
	end

endmodule

// ==== rtl/drawPosition.sv ====
// raster position counter issuing one slot per cycle with a frame-end strobe
`timescale 1ns/100ps

module drawPosition
	import pixelGenPkg::*;
#(
	parameter int pHActive = 480,
	parameter int pVActive = 272
)(
	input  logic    iCLK,
	input  logic    iRST,
	input  logic    room,
	output drawPosT pos
);

	// --------------------------------------------------
	// raster counters
	// --------------------------------------------------
	hposT hCnt;
	vposT vCnt;
	logic hLast;
	logic vLast;

	// last column and last line of the active area
	assign hLast = (hCnt == hposT'(pHActive - 1));
	assign vLast = (vCnt == vposT'(pVActive - 1));

	// advance only when the FIFO can take every pixel in flight
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (room)
		begin
			if (hLast)
			begin
				hCnt <= '0;
				// wrap to the top after the last line
				vCnt <= vLast ? '0 : vCnt + 1'b1;
			end
			else
			begin
				hCnt <= hCnt + 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// issued slot
	// --------------------------------------------------
	// position comes straight from the counter registers
	// no room means an invalid slot while the counters hold
	always_comb
	begin
		pos.valid    = room;
		pos.frameEnd = room & hLast & vLast;
		pos.hpos     = hCnt;
		pos.vpos     = vCnt;
	end

	// counters never leave the active area
	assert property (@(posedge iCLK) disable iff (iRST)
		(hCnt < hposT'(pHActive)) && (vCnt < vposT'(pVActive)));

endmodule

// ==== rtl/pixelGenPkg.sv ====
// raster widths, pixel and edge types, stage structs and pipeline constants
package pixelGenPkg;

	// --------------------------------------------------
	// raster and color widths
	// --------------------------------------------------
	localparam int lpHposWidth = 11;
	localparam int lpVposWidth = 11;
	// one extra bit so edges can sit left of or above the screen
	localparam int lpEdgeWidth = lpHposWidth + 1;
	localparam int lpChanWidth = 4;
	localparam int lpRgbWidth = 3 * lpChanWidth;

	typedef logic [lpHposWidth-1:0] hposT;
	typedef logic [lpVposWidth-1:0] vposT;
	typedef logic signed [lpEdgeWidth-1:0] edgeT;
	typedef logic [lpChanWidth-1:0] chanT;
	typedef logic [lpRgbWidth-1:0] rgbT;

	// --------------------------------------------------
	// square layer
	// --------------------------------------------------
	localparam int lpSquareNum = 7;

	// inclusive edges, left > right or top > under paints nothing
	typedef struct packed {
		rgbT  color;
		edgeT left;
		edgeT right;
		edgeT top;
		edgeT under;
	} squareT;

	// --------------------------------------------------
	// scene fade
	// --------------------------------------------------
	localparam int lpFadeWidth = 5;
	localparam int lpFadeMax = 16;
	localparam int lpFrameTimingWidth = 7;

	typedef logic [lpFadeWidth-1:0] fadeT;
	typedef logic [lpFrameTimingWidth-1:0] frameTimingT;

	typedef struct packed {
		rgbT         color;
		frameTimingT frameTiming;
		logic        addEn;
		logic        subEn;
		logic        fadeRst;
	} sceneCtrlT;

	// --------------------------------------------------
	// pipeline slots and output FIFO
	// --------------------------------------------------
	typedef struct packed {
		logic valid;
		logic frameEnd;
		hposT hpos;
		vposT vpos;
	} drawPosT;

	typedef struct packed {
		logic valid;
		logic frameEnd;
		rgbT  pixel;
	} pixelStageT;

	// registered stages between issue and FIFO write
	localparam int lpPipeDepth = 2;
	localparam int lpFifoDepth = 64;
	localparam int lpFifoPtrWidth = $clog2(lpFifoDepth);
	localparam int lpFifoCntWidth = $clog2(lpFifoDepth) + 1;

	typedef logic [lpFifoPtrWidth-1:0] fifoPtrT;
	typedef logic [lpFifoCntWidth-1:0] fifoCntT;

endpackage
